// File: compile.f
ems_pkg.sv
peripheral_decode.sv
ems_page_slot.sv
ems_read_mux.sv
ems_peripherals.sv
ems_checker.sv
tb_ems_peripherals.sv

// File: ems_checker.sv
// EMS mapper checker
// Mirrors the four page slots from the bus writes it sees, predicts
// selects, window hits and read data, and compares them with the DUT

module ems_checker
    import ems_pkg::*;
#(
    parameter int NAME_BITS = 8 * 24
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic [ADDR_WIDTH-1:0] address_i,
    input  logic [DATA_WIDTH-1:0] data_i,
    input  logic                  io_read_n_i,
    input  logic                  io_write_n_i,
    input  logic                  address_enable_n_i,
    input  logic                  ems_enable_i,
    input  logic [1:0]            ems_frame_select_i,
    input  logic                  dma_chip_select_n_i,
    input  logic                  dma_page_chip_select_n_i,
    input  logic [EMS_SLOTS-1:0]  ems_window_hit_i,
    input  logic [DATA_WIDTH-1:0] data_bus_i,
    input  logic                  data_bus_out_from_chipset_i,
    input  logic                  check_valid_i,
    input  int                    row_index_i,
    input  logic [NAME_BITS-1:0]  row_name_i,
    input  logic                  table_check_i,
    input  logic [DATA_WIDTH-1:0] table_data_i,
    input  logic [EMS_SLOTS-1:0]  table_hit_i,
    output int                    rows_checked_o,
    output int                    rows_passed_o,
    output int                    rows_failed_o
);

    logic [PAGE_WIDTH-1:0] model_page [EMS_SLOTS];
    logic                  model_enable [EMS_SLOTS];
    logic                  register_access;
    logic [1:0]            slot;
    logic                  sysboard;
    logic                  expected_dma_n;
    logic                  expected_page_n;
    logic                  expected_flag;
    logic [DATA_WIDTH-1:0] expected_data;
    logic [EMS_SLOTS-1:0]  expected_hit;
    logic [3:0]            frame_nibble;
    bit                    row_ok;

    // Upper address nibble of the 64 KB page frame
    function automatic logic [3:0] frame_upper(input logic [1:0] select);
        case (select)
            2'd0:    frame_upper = 4'hA;
            2'd1:    frame_upper = 4'hC;
            2'd2:    frame_upper = 4'hD;
            default: frame_upper = 4'hE;
        endcase
    endfunction

    task predict;
        register_access = ems_enable_i && !address_enable_n_i &&
            ((address_i[15:0] & 16'hFFFC) == 16'h0260);
        slot = address_i[1:0];
        expected_flag = register_access && !io_read_n_i;
        if (!expected_flag) begin
            expected_data = 8'h00;
        end else if (model_enable[slot]) begin
            expected_data = {1'b0, model_page[slot]};
        end else begin
            expected_data = 8'hFF;
        end
        // DMA at ports 000h..01Fh and DMA page at 080h..09Fh
        sysboard = !address_enable_n_i && (address_i[9:8] == 2'b00);
        expected_dma_n = !(sysboard && (address_i[7:5] == 3'd0));
        expected_page_n = !(sysboard && (address_i[7:5] == 3'd4));
        frame_nibble = frame_upper(ems_frame_select_i);
        for (int s = 0; s < EMS_SLOTS; s++) begin
            expected_hit[s] = model_enable[s] && (address_i[19:16] == frame_nibble) &&
                (address_i[15:14] == s[1:0]);
        end
    endtask

    task apply_write;
        if (register_access && !io_write_n_i) begin
            if (data_i == 8'hFF) begin
                model_page[slot] = 7'h7F;
                model_enable[slot] = 1'b0;
            end else if (data_i < 8'h80) begin
                model_page[slot] = data_i[6:0];
                model_enable[slot] = 1'b1;
            end
        end
    endtask

    task compare(input string what, input logic [7:0] got, input logic [7:0] expected);
        if (got !== expected) begin
            $display("ERROR at time %0t: row %0d %0s, %0s is %0h, expected %0h",
                $time, row_index_i, row_name_i, what, got, expected);
            row_ok = 1'b0;
        end
    endtask

    // Outputs settle after the falling edge and state moves only after this edge
    always @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int s = 0; s < EMS_SLOTS; s++) begin
                model_page[s] = '0;
                model_enable[s] = 1'b0;
            end
            rows_checked_o = 0;
            rows_passed_o = 0;
            rows_failed_o = 0;
        end else begin
            predict();
            if (check_valid_i) begin
                row_ok = 1'b1;
                compare("DMA select", 8'(dma_chip_select_n_i), 8'(expected_dma_n));
                compare("DMA page select", 8'(dma_page_chip_select_n_i), 8'(expected_page_n));
                compare("window hits", 8'(ems_window_hit_i), 8'(expected_hit));
                compare("chipset flag", 8'(data_bus_out_from_chipset_i), 8'(expected_flag));
                compare("data bus", data_bus_i, expected_data);
                if (table_check_i) begin
                    compare("data bus vs table", data_bus_i, table_data_i);
                    compare("window hits vs table", 8'(ems_window_hit_i), 8'(table_hit_i));
                end
                $display("row %0d %0s: %0s", row_index_i, row_name_i, row_ok ? "pass" : "fail");
                if (row_ok) begin
                    rows_passed_o = rows_passed_o + 1;
                end else begin
                    rows_failed_o = rows_failed_o + 1;
                end
                rows_checked_o = rows_checked_o + 1;
            end
            apply_write();
        end
    end

endmodule

// File: ems_page_slot.sv
// EMS page slot
// Holds one page number and its enable flag, flags accesses that fall
// in the slot's 16 KB window and returns the register readback byte

module ems_page_slot
    import ems_pkg::*;
#(
    parameter int SLOT_INDEX = 0
) (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        write_i,
    input  ems_write_word_t             write_word_i,
    input  logic [FRAME_BASE_WIDTH-1:0] frame_base_i,
    input  logic [ADDR_WIDTH-1:0]       address_i,
    output logic                        window_hit_o,
    output logic [DATA_WIDTH-1:0]       readback_o
);

    logic [PAGE_WIDTH-1:0]       page_q;
    logic                        enable_q;
    logic [WINDOW_TAG_WIDTH-1:0] window_tag;

    // FFh disables, 00h..7Fh maps a page, 80h..FEh is ignored
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            page_q   <= '0;
            enable_q <= 1'b0;
        end else if (write_i) begin
            if (write_word_i.raw == PAGE_DISABLE_CODE) begin
                page_q   <= PAGE_DISABLED_VALUE;
                enable_q <= 1'b0;
            end else if (!write_word_i.fields.command) begin
                page_q   <= write_word_i.fields.page;
                enable_q <= 1'b1;
            end
        end
    end

    // Slot windows sit one after another inside the 64 KB frame
    assign window_tag   = {frame_base_i, SLOT_SELECT_WIDTH'(SLOT_INDEX)};
    assign window_hit_o = enable_q &
        (address_i[ADDR_WIDTH-1 -: WINDOW_TAG_WIDTH] == window_tag);

    always_comb begin
        if (enable_q) begin
            readback_o = {{(DATA_WIDTH - PAGE_WIDTH){1'b0}}, page_q};
        end else begin
            readback_o = READ_DISABLED_VALUE;
        end
    end

endmodule

// File: ems_peripherals.sv
// EMS peripherals top level
// System-board I/O decode plus a four-slot EMS page mapper with
// register readback onto the chipset data bus

module ems_peripherals
    import ems_pkg::*;
(
    input  logic                          clock,
    input  logic                          reset,
    input  logic [ADDR_WIDTH-1:0]         address_i,
    input  logic [DATA_WIDTH-1:0]         data_i,
    input  logic                          io_read_n_i,
    input  logic                          io_write_n_i,
    input  logic                          address_enable_n_i,
    input  logic                          ems_enable_i,
    input  logic [FRAME_SELECT_WIDTH-1:0] ems_frame_select_i,
    output logic                          dma_chip_select_n_o,
    output logic                          dma_page_chip_select_n_o,
    output logic [EMS_SLOTS-1:0]          ems_window_hit_o,
    output logic [DATA_WIDTH-1:0]         data_bus_o,
    output logic                          data_bus_out_from_chipset_o
);

    ems_write_word_t                      write_word;
    logic [EMS_SLOTS-1:0]                 slot_write;
    logic [EMS_SLOTS-1:0]                 slot_read;
    logic [FRAME_BASE_WIDTH-1:0]          frame_base;
    logic [EMS_SLOTS-1:0][DATA_WIDTH-1:0] readback;

    peripheral_decode u_peripheral_decode (
        .address_i                (address_i),
        .data_i                   (data_i),
        .io_read_n_i              (io_read_n_i),
        .io_write_n_i             (io_write_n_i),
        .address_enable_n_i       (address_enable_n_i),
        .ems_enable_i             (ems_enable_i),
        .ems_frame_select_i       (ems_frame_select_i),
        .dma_chip_select_n_o      (dma_chip_select_n_o),
        .dma_page_chip_select_n_o (dma_page_chip_select_n_o),
        .write_word_o             (write_word),
        .slot_write_o             (slot_write),
        .slot_read_o              (slot_read),
        .frame_base_o             (frame_base)
    );

    // One slot per page register
    for (genvar i = 0; i < EMS_SLOTS; i++) begin : g_slot
        ems_page_slot #(
            .SLOT_INDEX (i)
        ) u_ems_page_slot (
            .clock        (clock),
            .reset        (reset),
            .write_i      (slot_write[i]),
            .write_word_i (write_word),
            .frame_base_i (frame_base),
            .address_i    (address_i),
            .window_hit_o (ems_window_hit_o[i]),
            .readback_o   (readback[i])
        );
    end

    ems_read_mux u_ems_read_mux (
        .slot_read_i                 (slot_read),
        .readback_i                  (readback),
        .data_bus_o                  (data_bus_o),
        .data_bus_out_from_chipset_o (data_bus_out_from_chipset_o)
    );

endmodule

// File: ems_pkg.sv
// EMS mapper package
// Bus widths, system-board and EMS port constants, frame bases,
// and the decoded view of a written data byte

package ems_pkg;

    // Bus widths
    localparam int ADDR_WIDTH = 20;
    localparam int DATA_WIDTH = 8;
    localparam int PAGE_WIDTH = 7;

    // Page slots and the address bits that pick one
    localparam int EMS_SLOTS         = 4;
    localparam int SLOT_SELECT_WIDTH = $clog2(EMS_SLOTS);

    // Four page registers at 260h..263h
    localparam logic [15:0] EMS_PORT_BASE = 16'h0260;

    // System-board I/O blocks of 32 ports each
    localparam int SYSBOARD_BLOCKS = 8;
    localparam int DMA_BLOCK       = 0;
    localparam int DMA_PAGE_BLOCK  = 4;

    // Frame upper nibble per frame select with A0000h at index 0
    localparam int FRAME_SELECT_WIDTH = 2;
    localparam int FRAME_BASE_WIDTH   = 4;
    localparam int WINDOW_TAG_WIDTH   = FRAME_BASE_WIDTH + SLOT_SELECT_WIDTH;
    localparam logic [3:0][FRAME_BASE_WIDTH-1:0] FRAME_BASES = {4'hE, 4'hD, 4'hC, 4'hA};

    // Page register codes
    localparam logic [DATA_WIDTH-1:0] PAGE_DISABLE_CODE   = 8'hFF;
    localparam logic [PAGE_WIDTH-1:0] PAGE_DISABLED_VALUE = 7'h7F;
    localparam logic [DATA_WIDTH-1:0] READ_DISABLED_VALUE = 8'hFF;

    // Written byte seen raw or as a command bit above a page number
    typedef union packed {
        logic [DATA_WIDTH-1:0] raw;
        struct packed {
            logic                  command;
            logic [PAGE_WIDTH-1:0] page;
        } fields;
    } ems_write_word_t;

endpackage

// File: ems_read_mux.sv
// EMS register read mux
// Puts the addressed slot's readback byte on the data bus and claims
// the bus for the chipset during an EMS register read

module ems_read_mux
    import ems_pkg::*;
(
    input  logic [EMS_SLOTS-1:0]                 slot_read_i,
    input  logic [EMS_SLOTS-1:0][DATA_WIDTH-1:0] readback_i,
    output logic [DATA_WIDTH-1:0]                data_bus_o,
    output logic                                 data_bus_out_from_chipset_o
);

    logic [DATA_WIDTH-1:0] selected;

    // One-hot strobe lets only the addressed byte through
    always_comb begin
        selected = '0;
        for (int i = 0; i < EMS_SLOTS; i++) begin
            if (slot_read_i[i]) begin
                selected = selected | readback_i[i];
            end
        end
    end

    always_comb begin
        if (|slot_read_i) begin
            data_bus_o                  = selected;
            data_bus_out_from_chipset_o = 1'b1;
        end else begin
            // Bus released
            data_bus_o                  = '0;
            data_bus_out_from_chipset_o = 1'b0;
        end
    end

endmodule

// File: peripheral_decode.sv
// System-board I/O decode
// Splits ports 000h..0FFh into 32-port blocks, strobes the four EMS
// page registers and looks up the EMS frame base

module peripheral_decode
    import ems_pkg::*;
(
    input  logic [ADDR_WIDTH-1:0]         address_i,
    input  logic [DATA_WIDTH-1:0]         data_i,
    input  logic                          io_read_n_i,
    input  logic                          io_write_n_i,
    input  logic                          address_enable_n_i,
    input  logic                          ems_enable_i,
    input  logic [FRAME_SELECT_WIDTH-1:0] ems_frame_select_i,
    output logic                          dma_chip_select_n_o,
    output logic                          dma_page_chip_select_n_o,
    output ems_write_word_t               write_word_o,
    output logic [EMS_SLOTS-1:0]          slot_write_o,
    output logic [EMS_SLOTS-1:0]          slot_read_o,
    output logic [FRAME_BASE_WIDTH-1:0]   frame_base_o
);

    logic                 sysboard_range;
    logic [2:0]           block;
    logic                 ems_range;
    logic [EMS_SLOTS-1:0] slot_one_hot;

    // Ports 000h..0FFh while the CPU owns the bus
    assign sysboard_range = ~address_enable_n_i & (address_i[9:8] == 2'b00);

    // Eight 32-port blocks of which only DMA and DMA page leave the block
    assign block = address_i[7:5];

    assign dma_chip_select_n_o      = ~(sysboard_range & (block == 3'(DMA_BLOCK)));
    assign dma_page_chip_select_n_o = ~(sysboard_range & (block == 3'(DMA_PAGE_BLOCK)));

    // EMS page registers
    assign ems_range = ems_enable_i & ~address_enable_n_i &
        (address_i[15:SLOT_SELECT_WIDTH] == EMS_PORT_BASE[15:SLOT_SELECT_WIDTH]);

    assign slot_one_hot = EMS_SLOTS'(1) << address_i[SLOT_SELECT_WIDTH-1:0];

    always_comb begin
        slot_write_o = '0;
        slot_read_o  = '0;
        if (ems_range) begin
            if (~io_write_n_i) begin
                slot_write_o = slot_one_hot;
            end
            if (~io_read_n_i) begin
                slot_read_o = slot_one_hot;
            end
        end
    end

    // Data byte goes to every slot and the strobe picks the one that takes it
    assign write_word_o = data_i;

    // A0000h, C0000h, D0000h or E0000h
    assign frame_base_o = FRAME_BASES[ems_frame_select_i];

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the EMS peripherals testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module tb_ems_peripherals \
    -f compile.f -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "^NO ERRORS$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

// File: tb_ems_peripherals.sv
// EMS peripherals testbench
// Applies a table of bus cycles to the DUT, one per clock, and lets
// the checker compare selects, window hits and register readback

module tb_ems_peripherals
    import ems_pkg::*;
();

    localparam int NAME_BITS  = 8 * 24;
    localparam int WAIT_LIMIT = 8;

    typedef struct packed {
        logic [NAME_BITS-1:0]  name;
        logic [ADDR_WIDTH-1:0] address;
        logic [DATA_WIDTH-1:0] data;
        logic                  read_n;
        logic                  write_n;
        logic                  address_enable_n;
        logic                  ems_enable;
        logic [1:0]            frame_select;
        logic                  table_check;
        logic [DATA_WIDTH-1:0] expected_data;
        logic [EMS_SLOTS-1:0]  expected_hit;
    } row_t;

    logic                  clock;
    logic                  reset;
    logic [ADDR_WIDTH-1:0] address;
    logic [DATA_WIDTH-1:0] data;
    logic                  io_read_n;
    logic                  io_write_n;
    logic                  address_enable_n;
    logic                  ems_enable;
    logic [1:0]            frame_select;
    logic                  dma_cs_n;
    logic                  dma_page_cs_n;
    logic [EMS_SLOTS-1:0]  window_hit;
    logic [DATA_WIDTH-1:0] data_bus;
    logic                  chipset_drives;
    logic                  check_valid;
    int                    row_index;
    logic [NAME_BITS-1:0]  row_name;
    logic                  table_check;
    logic [DATA_WIDTH-1:0] table_data;
    logic [EMS_SLOTS-1:0]  table_hit;
    int                    rows_checked;
    int                    rows_passed;
    int                    rows_failed;
    row_t                  rows[$];
    integer                seed;
    int                    row;
    bit                    timed_out;

    ems_peripherals dut0 (
        .clock                       (clock),
        .reset                       (reset),
        .address_i                   (address),
        .data_i                      (data),
        .io_read_n_i                 (io_read_n),
        .io_write_n_i                (io_write_n),
        .address_enable_n_i          (address_enable_n),
        .ems_enable_i                (ems_enable),
        .ems_frame_select_i          (frame_select),
        .dma_chip_select_n_o         (dma_cs_n),
        .dma_page_chip_select_n_o    (dma_page_cs_n),
        .ems_window_hit_o            (window_hit),
        .data_bus_o                  (data_bus),
        .data_bus_out_from_chipset_o (chipset_drives)
    );

    ems_checker #(
        .NAME_BITS (NAME_BITS)
    ) checker0 (
        .clock                       (clock),
        .reset                       (reset),
        .address_i                   (address),
        .data_i                      (data),
        .io_read_n_i                 (io_read_n),
        .io_write_n_i                (io_write_n),
        .address_enable_n_i          (address_enable_n),
        .ems_enable_i                (ems_enable),
        .ems_frame_select_i          (frame_select),
        .dma_chip_select_n_i         (dma_cs_n),
        .dma_page_chip_select_n_i    (dma_page_cs_n),
        .ems_window_hit_i            (window_hit),
        .data_bus_i                  (data_bus),
        .data_bus_out_from_chipset_i (chipset_drives),
        .check_valid_i               (check_valid),
        .row_index_i                 (row_index),
        .row_name_i                  (row_name),
        .table_check_i               (table_check),
        .table_data_i                (table_data),
        .table_hit_i                 (table_hit),
        .rows_checked_o              (rows_checked),
        .rows_passed_o               (rows_passed),
        .rows_failed_o               (rows_failed)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task add_row(input logic [NAME_BITS-1:0] name, input int addr, input int wdata,
                 input int rd_n, input int wr_n, input int ae_n, input int ems,
                 input int frame, input int exp_data, input int exp_hit, input int check);
        row_t r;
        r.name = name;
        r.address = addr[19:0];
        r.data = wdata[7:0];
        r.read_n = rd_n[0];
        r.write_n = wr_n[0];
        r.address_enable_n = ae_n[0];
        r.ems_enable = ems[0];
        r.frame_select = frame[1:0];
        r.expected_data = exp_data[7:0];
        r.expected_hit = exp_hit[3:0];
        r.table_check = check[0];
        rows.push_back(r);
    endtask

    task build_table;
        logic [31:0]           random_word;
        logic [ADDR_WIDTH-1:0] random_address;
        //       name                  addr     data  rd wr ae ems fs  data  hit chk
        add_row("rd 260 after reset",  'h00260, 'h00, 0, 1, 0, 1, 3, 'hFF, 'h0, 1);
        add_row("rd 261 after reset",  'h00261, 'h00, 0, 1, 0, 1, 3, 'hFF, 'h0, 1);
        add_row("rd 262 after reset",  'h00262, 'h00, 0, 1, 0, 1, 3, 'hFF, 'h0, 1);
        add_row("rd 263 after reset",  'h00263, 'h00, 0, 1, 0, 1, 3, 'hFF, 'h0, 1);
        add_row("E0000 no hit",        'hE0000, 'h00, 1, 1, 0, 1, 3, 'h00, 'h0, 1);
        add_row("wr 261 page 05",      'h00261, 'h05, 1, 0, 0, 1, 3, 'h00, 'h0, 1);
        add_row("rd 261 page 05",      'h00261, 'h00, 0, 1, 0, 1, 3, 'h05, 'h0, 1);
        add_row("E4000 hit slot 1",    'hE4000, 'h00, 1, 1, 0, 1, 3, 'h00, 'h2, 1);
        add_row("E7FFF hit slot 1",    'hE7FFF, 'h00, 1, 1, 0, 1, 3, 'h00, 'h2, 1);
        add_row("E8000 no hit",        'hE8000, 'h00, 1, 1, 0, 1, 3, 'h00, 'h0, 1);
        add_row("wr 261 80 ignored",   'h00261, 'h80, 1, 0, 0, 1, 3, 'h00, 'h0, 1);
        add_row("rd 261 after 80",     'h00261, 'h00, 0, 1, 0, 1, 3, 'h05, 'h0, 1);
        add_row("wr 261 FE ignored",   'h00261, 'hFE, 1, 0, 0, 1, 3, 'h00, 'h0, 1);
        add_row("rd 261 after FE",     'h00261, 'h00, 0, 1, 0, 1, 3, 'h05, 'h0, 1);
        add_row("wr 263 page 12",      'h00263, 'h12, 1, 0, 0, 1, 3, 'h00, 'h0, 1);
        add_row("rd 263 page 12",      'h00263, 'h00, 0, 1, 0, 1, 3, 'h12, 'h0, 1);
        add_row("EC000 hit slot 3",    'hEC000, 'h00, 1, 1, 0, 1, 3, 'h00, 'h8, 1);
        add_row("wr 261 FF disable",   'h00261, 'hFF, 1, 0, 0, 1, 3, 'h00, 'h0, 1);
        add_row("rd 261 disabled",     'h00261, 'h00, 0, 1, 0, 1, 3, 'hFF, 'h0, 1);
        add_row("E4000 hit dropped",   'hE4000, 'h00, 1, 1, 0, 1, 3, 'h00, 'h0, 1);
        add_row("frame A AC000",       'hAC000, 'h00, 1, 1, 0, 1, 0, 'h00, 'h8, 1);
        add_row("frame C CC000",       'hCC000, 'h00, 1, 1, 0, 1, 1, 'h00, 'h8, 1);
        add_row("frame D DC000",       'hDC000, 'h00, 1, 1, 0, 1, 2, 'h00, 'h8, 1);
        add_row("frame D EC000 miss",  'hEC000, 'h00, 1, 1, 0, 1, 2, 'h00, 'h0, 1);
        add_row("wr 263 ems off",      'h00263, 'h00, 1, 0, 0, 0, 3, 'h00, 'h0, 1);
        add_row("rd 263 ems off",      'h00263, 'h00, 0, 1, 0, 0, 3, 'h00, 'h0, 1);
        add_row("rd 263 ems on",       'h00263, 'h00, 0, 1, 0, 1, 3, 'h12, 'h0, 1);
        add_row("dma 000",             'h00000, 'h00, 1, 1, 0, 1, 3, 'h00, 'h0, 1);
        add_row("dma 01F",             'h0001F, 'h00, 1, 1, 0, 1, 3, 'h00, 'h0, 1);
        add_row("dma page 080",        'h00080, 'h00, 1, 1, 0, 1, 3, 'h00, 'h0, 1);
        add_row("dma page 09F",        'h0009F, 'h00, 1, 1, 0, 1, 3, 'h00, 'h0, 1);
        add_row("block 1 020",         'h00020, 'h00, 1, 1, 0, 1, 3, 'h00, 'h0, 1);
        add_row("dma 000 ae high",     'h00000, 'h00, 1, 1, 1, 1, 3, 'h00, 'h0, 1);
        // Filler addresses moved out of the DMA and DMA page blocks
        for (int i = 0; i < 4; i++) begin
            random_word = $random(seed);
            random_address = random_word[19:0];
            if (random_address[9:8] == 2'b00 &&
                (random_address[7:5] == 3'd0 || random_address[7:5] == 3'd4)) begin
                random_address[5] = 1'b1;
            end
            add_row("random address", {12'd0, random_address}, 'h00, 1, 1, 0, 1, 3,
                    'h00, 'h0, 0);
        end
    endtask

    task drive_idle;
        address = '0;
        data = '0;
        io_read_n = 1'b1;
        io_write_n = 1'b1;
        address_enable_n = 1'b1;
        ems_enable = 1'b1;
        frame_select = 2'd3;
        check_valid = 1'b0;
        row_index = 0;
        row_name = '0;
        table_check = 1'b0;
        table_data = '0;
        table_hit = '0;
    endtask

    task apply_row(input row_t r, input int index);
        address = r.address;
        data = r.data;
        io_read_n = r.read_n;
        io_write_n = r.write_n;
        address_enable_n = r.address_enable_n;
        ems_enable = r.ems_enable;
        frame_select = r.frame_select;
        check_valid = 1'b1;
        row_index = index;
        row_name = r.name;
        table_check = r.table_check;
        table_data = r.expected_data;
        table_hit = r.expected_hit;
    endtask

    // Checker counts a row on the rising edge and the count shows here at the falling edge
    task wait_for_check(input int target);
        int waited;
        waited = 0;
        while (rows_checked != target && waited < WAIT_LIMIT) begin
            @(negedge clock);
            waited++;
        end
        if (rows_checked != target) begin
            $display("Timeout: the checker never reported row %0d", target - 1);
            timed_out = 1'b1;
        end
    endtask

    initial begin
        seed = 9829;
        reset = 1'b1;
        timed_out = 1'b0;
        drive_idle();
        build_table();
        repeat (3) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        row = 0;
        while (row < rows.size() && !timed_out) begin
            apply_row(rows[row], row);
            wait_for_check(row + 1);
            row++;
        end
        drive_idle();
        $display("Rows checked %0d, passed %0d, failed %0d",
            rows_checked, rows_passed, rows_failed);
        if (timed_out || rows_failed != 0) begin
            $display("ERRORS FOUND");
        end else begin
            $display("NO ERRORS");
        end
        $finish;
    end

endmodule
